// File: logic/dmem_pkg.sv
/* Segment bounds, address word views and the request and
   character structs shared by the data memory blocks */

package dmem_pkg;

    // Segment bounds (byte addresses)
    localparam logic [31:0] DATA_BASE = 32'h0040_0000; // First data word
    localparam logic [31:0] STACK_TOP = 32'hffff_ffff; // Last stack byte

    // One address word, read as bytes or as word index plus lane
    typedef union packed {
        logic [31:0] byte_addr;
        struct packed {
            logic [29:0] word;
            logic [1:0]  off;
        } fields;
    } mem_addr_u;

    typedef enum logic [1:0] {
        SEG_NONE,
        SEG_DATA,
        SEG_STACK
    } seg_e;

    // Processor side request, 65 bits
    typedef struct packed {
        logic        write;
        mem_addr_u   addr;
        logic [31:0] wdata;
    } mem_req_t;

    // Printed character
    typedef struct packed {
        logic [7:0] ch;
        logic       last;  // Final char before NUL
    } chr_t;

endpackage

// File: logic/segment_decoder.sv
/* Segment decoder mapping a byte address to segment,
   local word index and fault flag */

`timescale 1ns/10ps

module segment_decoder #(
    parameter int DATA_WORDS  = 1024,
    parameter int STACK_WORDS = 1024
) (
    input  dmem_pkg::mem_addr_u addr,
    output dmem_pkg::seg_e      seg,
    output logic [31:0]         index,
    output logic                fault
);

    import dmem_pkg::*;

    // Word bounds of both segments, inclusive
    localparam logic [29:0] DATA_LO  = DATA_BASE[31:2];
    localparam logic [29:0] DATA_HI  = DATA_LO + 30'(DATA_WORDS) - 30'd1;
    localparam logic [29:0] STACK_HI = STACK_TOP[31:2];
    localparam logic [29:0] STACK_LO = STACK_HI - 30'(STACK_WORDS) + 30'd1;

    logic [29:0] word;

    always_comb begin
        word = addr.fields.word;
        if (word >= DATA_LO && word <= DATA_HI) begin
            seg   = SEG_DATA;
            index = {2'b00, word - DATA_LO};
        end else if (word >= STACK_LO && word <= STACK_HI) begin
            seg   = SEG_STACK;
            index = {2'b00, word - STACK_LO};
        end else begin
            seg   = SEG_NONE;  // Between segments or below data
            index = 32'd0;
        end
    end

    assign fault = (seg == SEG_NONE);

endmodule

// File: logic/word_ram.sv
/* Single port word RAM with registered read */

`timescale 1ns/10ps

module word_ram #(
    parameter int DEPTH = 1024
) (
    input  logic        clk,
    input  logic        en,
    input  logic        we,
    input  logic [31:0] index,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int AW = $clog2(DEPTH);

    logic [31:0] mem [DEPTH];
    logic [AW-1:0] waddr;

    // Decoder keeps index inside DEPTH
    assign waddr = index[AW-1:0];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[waddr] <= wdata;
            end else begin
                rdata <= mem[waddr];  // Held until the next read
            end
        end
    end

endmodule

// File: logic/byte_lane_select.sv
/* Little endian byte lane mux with NUL detect */

`timescale 1ns/10ps

module byte_lane_select (
    input  logic [31:0] word,
    input  logic [1:0]  offset,
    output logic [7:0]  ch,
    output logic        is_nul
);

    always_comb begin
        case (offset)
            2'd0: ch = word[7:0];
            2'd1: ch = word[15:8];
            2'd2: ch = word[23:16];
            default: ch = word[31:24];
        endcase
    end

    assign is_nul = (ch == 8'h00);  // String terminator

endmodule

// File: logic/dmem_control.sv
/* Data memory control FSM serving the processor port, the
   print string walk and the character handshake */

`timescale 1ns/10ps

module dmem_control (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_valid,
    input  dmem_pkg::mem_req_t  cpu_req,
    output logic                cpu_ready,
    output logic                rd_valid,
    output logic                seg_fault,
    input  logic                sys_req,
    input  logic [31:0]         sys_addr,
    output logic                sys_ack,
    output logic                chr_req,
    input  logic                chr_ack,
    output dmem_pkg::chr_t      chr_out,
    output dmem_pkg::mem_addr_u dec_addr,
    input  dmem_pkg::seg_e      dec_seg,
    input  logic                dec_fault,
    output logic                data_en,
    output logic                data_we,
    output logic                stack_en,
    output logic                stack_we,
    output logic                sel_stack,
    input  logic [7:0]          lane_ch,
    input  logic                lane_nul,
    output logic [1:0]          lane_off
);

    import dmem_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ACCESS_WAIT,
        PRINT_READ,
        PRINT_LOOK,
        PRINT_SEND,
        PRINT_RELEASE,
        SYS_DONE
    } state_e;

    state_e      state;
    mem_addr_u   ptr;         // Next byte to read during a walk
    logic [7:0]  cur_ch;
    logic        have_cur;    // cur_ch holds a char not yet sent
    logic        walk_fault;
    logic        acc_fault;
    logic        cpu_acc;
    logic        issue_cpu;
    logic        issue_walk;
    logic        ram_we;

    // ############################
    // Port and RAM strobes
    // ############################

    always_comb begin
        cpu_ready  = (state == IDLE) && !sys_req;  // Print call wins
        cpu_acc    = cpu_valid && cpu_ready;
        dec_addr   = (state == IDLE) ? cpu_req.addr : ptr;
        issue_cpu  = cpu_acc && !dec_fault;
        issue_walk = (state == PRINT_READ) && !dec_fault;
        ram_we     = issue_cpu && cpu_req.write;
        data_en    = (issue_cpu || issue_walk) && (dec_seg == SEG_DATA);
        data_we    = ram_we && (dec_seg == SEG_DATA);
        stack_en   = (issue_cpu || issue_walk) && (dec_seg == SEG_STACK);
        stack_we   = ram_we && (dec_seg == SEG_STACK);
    end

    assign lane_off = ptr.fields.off;
    assign sys_ack  = (state == SYS_DONE);
    assign chr_req  = (state == PRINT_SEND);

    // ############################
    // FSM
    // ############################

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            rd_valid   <= 1'b0;
            seg_fault  <= 1'b0;
            acc_fault  <= 1'b0;
            have_cur   <= 1'b0;
            walk_fault <= 1'b0;
        end else begin
            rd_valid  <= 1'b0;
            seg_fault <= 1'b0;
            case (state)
                IDLE: begin
                    if (sys_req) begin
                        have_cur   <= 1'b0;
                        walk_fault <= 1'b0;
                        state      <= PRINT_READ;
                    end else if (cpu_acc && (dec_fault || !cpu_req.write)) begin
                        acc_fault <= dec_fault;  // Good writes stay in IDLE
                        state     <= ACCESS_WAIT;
                    end
                end
                ACCESS_WAIT: begin
                    rd_valid  <= !acc_fault;
                    seg_fault <= acc_fault;
                    state     <= IDLE;
                end
                PRINT_READ: begin
                    if (!dec_fault) begin
                        state <= PRINT_LOOK;
                    end else if (have_cur) begin
                        walk_fault <= 1'b1;  // Walked off, send what we hold
                        state      <= PRINT_SEND;
                    end else begin
                        seg_fault <= 1'b1;
                        state     <= SYS_DONE;
                    end
                end
                PRINT_LOOK: begin
                    if (have_cur) begin
                        state <= PRINT_SEND;
                    end else if (lane_nul) begin
                        state <= SYS_DONE;   // Empty string
                    end else begin
                        have_cur <= 1'b1;
                        state    <= PRINT_READ;
                    end
                end
                PRINT_SEND: begin
                    if (chr_ack) state <= PRINT_RELEASE;
                end
                PRINT_RELEASE: begin
                    if (!chr_ack) begin
                        if (chr_out.last) begin
                            seg_fault <= walk_fault;
                            state     <= SYS_DONE;
                        end else begin
                            state <= PRINT_READ;
                        end
                    end
                end
                SYS_DONE: begin
                    if (!sys_req) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Walk pointer, characters and read select
    always_ff @(posedge clk) begin
        if (issue_cpu && !cpu_req.write || issue_walk) begin
            sel_stack <= (dec_seg == SEG_STACK);
        end
        case (state)
            IDLE: begin
                if (sys_req) ptr.byte_addr <= sys_addr;
            end
            PRINT_READ: begin
                if (dec_fault) chr_out.last <= 1'b1;
                if (dec_fault) chr_out.ch <= cur_ch;
            end
            PRINT_LOOK: begin
                cur_ch <= lane_ch;
                if (have_cur) begin
                    chr_out.ch   <= cur_ch;
                    chr_out.last <= lane_nul;  // Look-ahead byte is NUL
                end else if (!lane_nul) begin
                    ptr.byte_addr <= ptr.byte_addr + 32'd1;
                end
            end
            PRINT_RELEASE: begin
                if (!chr_ack && !chr_out.last) begin
                    ptr.byte_addr <= ptr.byte_addr + 32'd1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: logic/data_memory.sv
/* Data memory top with segment decoder, data and stack RAMs,
   byte lane select and control */

`timescale 1ns/10ps

module data_memory #(
    parameter int DATA_WORDS  = 1024,
    parameter int STACK_WORDS = 1024
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_valid,
    input  dmem_pkg::mem_req_t cpu_req,
    output logic               cpu_ready,
    output logic [31:0]        rdata,
    output logic               rd_valid,
    output logic               seg_fault,
    input  logic               sys_req,
    input  logic [31:0]        sys_addr,
    output logic               sys_ack,
    output logic               chr_req,
    input  logic               chr_ack,
    output dmem_pkg::chr_t     chr_out
);

    import dmem_pkg::*;

    mem_addr_u   dec_addr;
    seg_e        dec_seg;
    logic [31:0] dec_index;
    logic        dec_fault;
    logic        data_en;
    logic        data_we;
    logic        stack_en;
    logic        stack_we;
    logic        sel_stack;
    logic [31:0] data_rdata;
    logic [31:0] stack_rdata;
    logic [7:0]  lane_ch;
    logic        lane_nul;
    logic [1:0]  lane_off;

    segment_decoder #(
        .DATA_WORDS  (DATA_WORDS),
        .STACK_WORDS (STACK_WORDS)
    ) decoder (
        .addr  (dec_addr),
        .seg   (dec_seg),
        .index (dec_index),
        .fault (dec_fault)
    );

    word_ram #(.DEPTH(DATA_WORDS)) data_ram (
        .clk   (clk),
        .en    (data_en),
        .we    (data_we),
        .index (dec_index),
        .wdata (cpu_req.wdata),
        .rdata (data_rdata)
    );

    word_ram #(.DEPTH(STACK_WORDS)) stack_ram (
        .clk   (clk),
        .en    (stack_en),
        .we    (stack_we),
        .index (dec_index),
        .wdata (cpu_req.wdata),
        .rdata (stack_rdata)
    );

    assign rdata = sel_stack ? stack_rdata : data_rdata;  // Last segment read

    byte_lane_select lane_sel (
        .word   (rdata),
        .offset (lane_off),
        .ch     (lane_ch),
        .is_nul (lane_nul)
    );

    dmem_control control (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .rd_valid  (rd_valid),
        .seg_fault (seg_fault),
        .sys_req   (sys_req),
        .sys_addr  (sys_addr),
        .sys_ack   (sys_ack),
        .chr_req   (chr_req),
        .chr_ack   (chr_ack),
        .chr_out   (chr_out),
        .dec_addr  (dec_addr),
        .dec_seg   (dec_seg),
        .dec_fault (dec_fault),
        .data_en   (data_en),
        .data_we   (data_we),
        .stack_en  (stack_en),
        .stack_we  (stack_we),
        .sel_stack (sel_stack),
        .lane_ch   (lane_ch),
        .lane_nul  (lane_nul),
        .lane_off  (lane_off)
    );

endmodule

// File: tests/tb_data_memory.sv
/* Testbench for the data memory with a reference model, a port
   and character checker, and a random-delay character consumer */

`timescale 1ns/10ps

module tb_data_memory;

    import dmem_pkg::*;

    localparam int DATA_WORDS  = 1024;
    localparam int STACK_WORDS = 1024;
    localparam int PAIRS       = 16;   // Writes per segment in the read-back test
    localparam int STR_LEN     = 12;
    localparam int TOP_LEN     = 7;    // Bytes up to the stack top

    localparam logic [31:0] DATA_END   = DATA_BASE + 32'(4 * DATA_WORDS);
    localparam logic [31:0] STACK_BASE = STACK_TOP - 32'(4 * STACK_WORDS) + 32'd1;

    // Run length in accesses (print calls included) and characters
    localparam int PLANNED_ACC = 4 * PAIRS + 8 + 7 + 2 + 3;
    localparam int PLANNED_CHR = 2 * STR_LEN + TOP_LEN;
    localparam int CYCLE_LIMIT = 4 * (PLANNED_ACC + 8 * PLANNED_CHR);

    logic     clk = 1'b0;
    logic     rst;
    logic     cpu_valid;
    mem_req_t cpu_req;
    logic     cpu_ready;
    logic [31:0] rdata;
    logic     rd_valid;
    logic     seg_fault;
    logic     sys_req;
    logic [31:0] sys_addr;
    logic     sys_ack;
    logic     chr_req;
    logic     chr_ack;
    chr_t     chr_out;

    integer      seed;
    int          cycle_count = 0;
    logic [31:0] ref_mem [logic [31:0]];   // Words by aligned byte address
    logic [7:0]  exp_chars [$];
    logic        exp_walk_fault;
    int          chr_idx;

    data_memory #(
        .DATA_WORDS  (DATA_WORDS),
        .STACK_WORDS (STACK_WORDS)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .rdata     (rdata),
        .rd_valid  (rd_valid),
        .seg_fault (seg_fault),
        .sys_req   (sys_req),
        .sys_addr  (sys_addr),
        .sys_ack   (sys_ack),
        .chr_req   (chr_req),
        .chr_ack   (chr_ack),
        .chr_out   (chr_out)
    );

    always #5 clk = ~clk;

    // ##############################
    // Reference model
    // ##############################

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        if (ref_mem.exists(w)) ref_read = ref_mem[w];
        else ref_read = 32'd0;   // Never written
    endfunction

    function automatic bit ref_in_segment(input logic [31:0] a);
        ref_in_segment = (a >= DATA_BASE && a < DATA_END) || (a >= STACK_BASE);
    endfunction

    // Expected characters of a print call, little endian
    function automatic void ref_string(input logic [31:0] start);
        logic [31:0] a;
        logic [31:0] w;
        logic [7:0]  b;
        bit          done;
        exp_chars.delete();
        exp_walk_fault = 1'b0;
        a = start;
        done = 1'b0;
        while (!done) begin
            if (!ref_in_segment(a)) begin
                exp_walk_fault = 1'b1;
                done = 1'b1;
            end else begin
                w = ref_read(a);
                b = w[8 * a[1:0] +: 8];
                if (b == 8'h00) begin
                    done = 1'b1;
                end else begin
                    exp_chars.push_back(b);
                    a = a + 32'd1;
                end
            end
        end
    endfunction

    // ##############################
    // Reporting
    // ##############################

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("error: time %0t, %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else
            abort_run($sformatf("error: time %0t, %s is %b, expected %b",
                                $time, name, got, exp));
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: tests did not finish within %0d cycles",
                                CYCLE_LIMIT));
        end
    end

    // ##############################
    // Checker
    // ##############################

    logic        p1_rd;
    logic        p1_fault;
    logic        p2_rd;
    logic        p2_fault;
    logic [31:0] p1_word;
    logic [31:0] p2_word;
    logic        ack_prev;
    logic        req_prev;

    // Outputs sampled at the falling edge, responses due two edges after acceptance
    always @(negedge clk) begin
        if (rst) begin
            p1_rd    = 1'b0;
            p1_fault = 1'b0;
            p2_rd    = 1'b0;
            p2_fault = 1'b0;
            ack_prev = 1'b0;
            req_prev = 1'b0;
        end else begin
            expect_bit("rd_valid", rd_valid, p2_rd);
            if (p2_rd) begin
                expect_word("rdata", rdata, p2_word);
            end
            expect_bit("seg_fault", seg_fault,
                       p2_fault || (sys_ack && !ack_prev && exp_walk_fault));
            assert (!(cpu_ready && (sys_req || sys_ack))) else
                abort_run("cpu_ready was high while a print call was in progress");
            if (chr_req && !req_prev) begin
                assert (chr_idx < exp_chars.size()) else
                    abort_run("a character was sent beyond the end of the string");
                expect_word("chr_out.ch", chr_out.ch, exp_chars[chr_idx]);
                expect_bit("chr_out.last", chr_out.last, chr_idx == exp_chars.size() - 1);
                chr_idx++;
            end
            if (sys_ack && !ack_prev) begin
                assert (chr_idx == exp_chars.size() && !chr_req) else
                    abort_run("sys_ack rose before every character was handed over");
            end
            p2_rd    = p1_rd;
            p2_fault = p1_fault;
            p2_word  = p1_word;
            p1_rd    = 1'b0;
            p1_fault = 1'b0;
            if (cpu_valid && cpu_ready) begin   // Accepted at the next edge
                if (!ref_in_segment(cpu_req.addr.byte_addr)) begin
                    p1_fault = 1'b1;
                end else if (cpu_req.write) begin
                    ref_mem[{cpu_req.addr.fields.word, 2'b00}] = cpu_req.wdata;
                end else begin
                    p1_rd   = 1'b1;
                    p1_word = ref_read(cpu_req.addr.byte_addr);
                end
            end
            ack_prev = sys_ack;
            req_prev = chr_req;
        end
    end

    // Character consumer, answers after 0 to 6 cycles
    initial begin : ack_responder
        int unsigned ack_delay;
        chr_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (chr_req) begin
                ack_delay = $unsigned($random(seed)) % 7;
                repeat (ack_delay) @(posedge clk);
                @(posedge clk);
                #1 chr_ack = 1'b1;
                @(negedge clk);
                while (chr_req) @(negedge clk);
                @(posedge clk);
                #1 chr_ack = 1'b0;
            end
        end
    end

    // ##############################
    // Stimulus
    // ##############################

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic cpu_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata);
        cpu_req.write          = wr;
        cpu_req.addr.byte_addr = addr;
        cpu_req.wdata          = wdata;
        cpu_valid              = 1'b1;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        step();
        cpu_valid = 1'b0;
    endtask

    // Random printable bytes from start, stored as whole words
    task automatic put_string(input logic [31:0] start, input int len, input bit nul_end);
        logic [31:0] words [8];
        logic [31:0] base;
        logic [31:0] rel;
        int          nwords;
        int          i;
        base   = {start[31:2], 2'b00};
        nwords = (start[1:0] + len + nul_end + 3) / 4;
        for (i = 0; i < nwords; i++) words[i] = ref_read(base + 32'(4 * i));
        for (i = 0; i < len + nul_end; i++) begin
            rel = start[1:0] + i;
            if (i < len) begin
                words[rel[31:2]][8 * rel[1:0] +: 8] =
                    8'h20 + 8'($unsigned($random(seed)) % 95);
            end else begin
                words[rel[31:2]][8 * rel[1:0] +: 8] = 8'h00;
            end
        end
        for (i = 0; i < nwords; i++) cpu_access(1'b1, base + 32'(4 * i), words[i]);
    endtask

    task automatic print_call(input logic [31:0] addr);
        ref_string(addr);
        chr_idx  = 0;
        sys_addr = addr;
        sys_req  = 1'b1;
        @(negedge clk);
        while (!sys_ack) @(negedge clk);
        step();
        sys_req = 1'b0;
        @(negedge clk);
        while (sys_ack) @(negedge clk);
        step();
    endtask

    initial begin : stimulus
        logic [31:0] t1_addr [2 * PAIRS];
        logic [31:0] str_addr;
        int          i;
        seed           = 32'h3883_b024;
        rst            = 1'b1;
        cpu_valid      = 1'b0;
        cpu_req        = '0;
        sys_req        = 1'b0;
        sys_addr       = 32'd0;
        exp_walk_fault = 1'b0;
        chr_idx        = 0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        // State right after reset
        @(negedge clk);
        expect_bit("cpu_ready", cpu_ready, 1'b1);
        expect_bit("rd_valid", rd_valid, 1'b0);
        expect_bit("seg_fault", seg_fault, 1'b0);
        expect_bit("sys_ack", sys_ack, 1'b0);
        expect_bit("chr_req", chr_req, 1'b0);
        step();

        // Write and read back in both segments
        for (i = 0; i < PAIRS; i++) begin
            t1_addr[i] = DATA_BASE + 32'(4 * ($unsigned($random(seed)) % DATA_WORDS));
            t1_addr[PAIRS + i] =
                STACK_BASE + 32'(4 * ($unsigned($random(seed)) % STACK_WORDS));
        end
        for (i = 0; i < 2 * PAIRS; i++) cpu_access(1'b1, t1_addr[i], $random(seed));
        for (i = 2 * PAIRS - 1; i >= 0; i--) cpu_access(1'b0, t1_addr[i], 32'd0);

        // Faults leave word 0 of both RAMs alone
        cpu_access(1'b1, DATA_BASE, $random(seed));
        cpu_access(1'b1, STACK_BASE, $random(seed));
        cpu_access(1'b1, 32'h8000_0000, $random(seed));   // Between segments
        cpu_access(1'b0, 32'h8000_0000, 32'd0);
        cpu_access(1'b1, 32'h0000_1000, $random(seed));   // Below data
        cpu_access(1'b0, DATA_BASE - 32'd4, 32'd0);
        cpu_access(1'b0, DATA_BASE, 32'd0);
        cpu_access(1'b0, STACK_BASE, 32'd0);

        // Print calls, plain and empty
        str_addr = DATA_BASE + 32'h800 + 32'(1 + $unsigned($random(seed)) % 3);
        put_string(str_addr, STR_LEN, 1'b1);
        print_call(str_addr);
        put_string(DATA_BASE + 32'h902, 0, 1'b1);
        print_call(DATA_BASE + 32'h902);

        // Processor read held off by a running call
        fork
            print_call(str_addr);
            begin
                repeat (2) step();
                cpu_access(1'b0, t1_addr[0], 32'd0);
            end
        join

        // String runs off the stack top
        put_string(STACK_TOP - 32'(TOP_LEN - 1), TOP_LEN, 1'b0);
        print_call(STACK_TOP - 32'(TOP_LEN - 1));

        repeat (4) step();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: build.f
logic/dmem_pkg.sv
logic/segment_decoder.sv
logic/word_ram.sv
logic/byte_lane_select.sv
logic/dmem_control.sv
logic/data_memory.sv
tests/tb_data_memory.sv
